// ==== design/decoder_config.svh ====
// Decoder width configuration

`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

////////////////////////////////////////////////////////////
// Widths fixed by the RV32I ISA
////////////////////////////////////////////////////////////

`define XLEN_W      32  // Data and instruction width
`define REG_ADDR_W  5   // x0..x31

////////////////////////////////////////////////////////////
// Widths of the decoded control fields
////////////////////////////////////////////////////////////

`define ALU_OP_W    4   // {instr[30], funct3}
`define LSU_CTRL_W  4   // {is_store, funct3}

`endif

// ==== design/rv32_isa_pkg.sv ====
// RV32I ISA types

`default_nettype none

`include "decoder_config.svh"

package rv32_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Basic field types
    ////////////////////////////////////////////////////////////

    typedef logic [`XLEN_W-1:0]     word_t;      // Instruction word or immediate
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // Register file address
    typedef logic [2:0]             funct3_t;

    // Shift encodings of funct3 in OP-IMM
    localparam funct3_t FUNCT3_SLL = 3'b001;
    localparam funct3_t FUNCT3_SRX = 3'b101;  // SRLI and SRAI share it

    // Legal funct7 values for immediate shifts
    localparam logic [6:0] FUNCT7_ZERO = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    ////////////////////////////////////////////////////////////
    // Major opcodes handled by the decoder
    ////////////////////////////////////////////////////////////

    // Branches, jumps, FENCE and SYSTEM are not listed and decode as illegal
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

endpackage

`default_nettype wire

// ==== design/decode_pkg.sv ====
// Decoder control and bundle types

`default_nettype none

`include "decoder_config.svh"

package decode_pkg;

    typedef logic [`ALU_OP_W-1:0]   alu_op_t;    // {instr[30], funct3}
    typedef logic [`LSU_CTRL_W-1:0] lsu_ctrl_t;  // {is_store, funct3}

    localparam alu_op_t ALU_OP_ADD = '0;

    // Immediate format select, none must stay zero
    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_S     = 3'd2,
        IMM_U     = 3'd3,
        IMM_SHAMT = 3'd4
    } imm_fmt_e;

    ////////////////////////////////////////////////////////////
    // Bundles between the decoder parts
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        rv32_isa_pkg::word_t i_imm;
        rv32_isa_pkg::word_t s_imm;
        rv32_isa_pkg::word_t u_imm;
        rv32_isa_pkg::word_t shamt;     // Zero extended
    } imm_cand_t;

    typedef struct packed {
        rv32_isa_pkg::reg_addr_t rs1;
        rv32_isa_pkg::reg_addr_t rs2;
        rv32_isa_pkg::reg_addr_t rd;
    } reg_fields_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_pc;     // Operand A is the PC
        logic      op_b_imm;   // Operand B is the immediate
        logic      wb;
        logic      uses_rs1;
        logic      uses_rs2;
        imm_fmt_e  imm_fmt;
        logic      lsu_valid;
        lsu_ctrl_t lsu_ctrl;
        logic      illegal;
    } ctrl_t;

    ////////////////////////////////////////////////////////////
    // Decoder output
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_t                 alu_op;
        logic                    use_pc;
        logic                    op_b_imm;
        logic                    wb;
        rv32_isa_pkg::reg_addr_t rs1;       // Zero when unused
        rv32_isa_pkg::reg_addr_t rs2;       // Zero when unused
        rv32_isa_pkg::reg_addr_t rd;        // Zero for stores and illegal
        rv32_isa_pkg::word_t     imm;
        logic                    lsu_valid;
        lsu_ctrl_t               lsu_ctrl;
        logic                    illegal;
    } decoded_t;

    typedef enum logic {
        RUN   = 1'b0,
        STALL = 1'b1
    } stall_state_e;

endpackage

`default_nettype wire

// ==== design/operand_unit.sv ====
// Register fields and immediates

`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module operand_unit (
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,
    input  wire rv32_isa_pkg::word_t     instr_i,
    input  wire logic                    instr_accept_i,
    output decode_pkg::reg_fields_t      fields_o,
    output decode_pkg::imm_cand_t        imm_cand_o,
    output logic                         rs1_match_o,
    output logic                         rs2_match_o
);

    rv32_isa_pkg::reg_addr_t prev_rd_q;  // Destination of last accepted instr

    ////////////////////////////////////////////////////////////
    // Register fields
    ////////////////////////////////////////////////////////////

    assign fields_o.rs1 = instr_i[19:15];
    assign fields_o.rs2 = instr_i[24:20];
    assign fields_o.rd  = instr_i[11:7];   // Taken for every opcode, stores too

    ////////////////////////////////////////////////////////////
    // Immediate candidates
    ////////////////////////////////////////////////////////////

    assign imm_cand_o.i_imm = {{(`XLEN_W-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_cand_o.s_imm = {{(`XLEN_W-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_cand_o.u_imm = {instr_i[31:12], 12'b0};

    // Shift amount is never negative
    assign imm_cand_o.shamt = {{(`XLEN_W-5){1'b0}}, instr_i[24:20]};

    ////////////////////////////////////////////////////////////
    // Read-after-write detection
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            prev_rd_q <= '0;
        end else if (instr_accept_i) begin
            prev_rd_q <= instr_i[11:7];
        end
    end

    // x0 is hardwired, so a match on it is no hazard
    assign rs1_match_o = (fields_o.rs1 == prev_rd_q) && (fields_o.rs1 != '0);
    assign rs2_match_o = (fields_o.rs2 == prev_rd_q) && (fields_o.rs2 != '0);

endmodule

`default_nettype wire

// ==== design/ctrl_decode.sv ====
// Opcode and funct decoder

`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module ctrl_decode (
    input  wire rv32_isa_pkg::word_t instr_i,
    output decode_pkg::ctrl_t        ctrl_o
);

    rv32_isa_pkg::opcode_e opcode;
    rv32_isa_pkg::funct3_t funct3;
    logic [6:0]            funct7;
    logic                  is_shift;  // OP-IMM with a legal shift encoding

    assign opcode = rv32_isa_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign is_shift = ((funct3 == rv32_isa_pkg::FUNCT3_SLL) ||
                       (funct3 == rv32_isa_pkg::FUNCT3_SRX)) &&
                      ((funct7 == rv32_isa_pkg::FUNCT7_ZERO) ||
                       (funct7 == rv32_isa_pkg::FUNCT7_ALT));

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Defaults describe an instruction that does nothing
        ctrl_o          = '0;
        ctrl_o.alu_op   = decode_pkg::ALU_OP_ADD;
        ctrl_o.imm_fmt  = decode_pkg::IMM_NONE;

        case (opcode)
            rv32_isa_pkg::OPC_OP: begin
                ctrl_o.alu_op   = {instr_i[30], funct3};
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.uses_rs2 = 1'b1;
                ctrl_o.wb       = 1'b1;
            end

            rv32_isa_pkg::OPC_OP_IMM: begin
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.wb       = 1'b1;
                if (is_shift) begin
                    ctrl_o.alu_op  = {instr_i[30], funct3};  // Bit 30 picks SRA
                    ctrl_o.imm_fmt = decode_pkg::IMM_SHAMT;
                end else begin
                    ctrl_o.alu_op  = {1'b0, funct3};
                    ctrl_o.imm_fmt = decode_pkg::IMM_I;
                end
            end

            rv32_isa_pkg::OPC_LUI: begin
                ctrl_o.imm_fmt = decode_pkg::IMM_U;
                ctrl_o.wb      = 1'b1;
            end

            rv32_isa_pkg::OPC_AUIPC: begin
                ctrl_o.imm_fmt = decode_pkg::IMM_U;
                ctrl_o.use_pc  = 1'b1;  // PC + upper immediate
                ctrl_o.wb      = 1'b1;
            end

            rv32_isa_pkg::OPC_LOAD: begin
                ctrl_o.imm_fmt   = decode_pkg::IMM_I;
                ctrl_o.uses_rs1  = 1'b1;
                ctrl_o.lsu_valid = 1'b1;
                ctrl_o.lsu_ctrl  = {1'b0, funct3};
            end

            rv32_isa_pkg::OPC_STORE: begin
                ctrl_o.imm_fmt   = decode_pkg::IMM_S;
                ctrl_o.uses_rs1  = 1'b1;
                ctrl_o.uses_rs2  = 1'b1;  // Store data
                ctrl_o.lsu_valid = 1'b1;
                ctrl_o.lsu_ctrl  = {1'b1, funct3};
            end

            default: begin
                ctrl_o.alu_op  = '0;
                ctrl_o.illegal = 1'b1;
            end
        endcase

        // Operand B follows the immediate format
        ctrl_o.op_b_imm = (ctrl_o.imm_fmt != decode_pkg::IMM_NONE);
    end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
// Decode stage with stall FSM

`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module decode_stage (
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,
    input  wire logic                    instr_valid_i,
    input  wire decode_pkg::reg_fields_t fields_i,
    input  wire decode_pkg::imm_cand_t   imm_cand_i,
    input  wire logic                    rs1_match_i,
    input  wire logic                    rs2_match_i,
    input  wire decode_pkg::ctrl_t       ctrl_i,
    input  wire logic                    dec_ready_i,
    output logic                         instr_ready_o,
    output logic                         instr_accept_o,
    output logic                         dec_valid_o,
    output decode_pkg::decoded_t         dec_o
);

    decode_pkg::stall_state_e state_q;
    decode_pkg::stall_state_e state_d;
    decode_pkg::decoded_t     dec_d;
    logic                     hazard;
    logic                     out_space;  // Output register free this cycle
    logic                     is_store;

    ////////////////////////////////////////////////////////////
    // Stall FSM and input handshake
    ////////////////////////////////////////////////////////////

    assign hazard    = (ctrl_i.uses_rs1 && rs1_match_i) || (ctrl_i.uses_rs2 && rs2_match_i);
    assign out_space = !dec_valid_o || dec_ready_i;

    // In STALL the bubble is already spent
    assign instr_ready_o  = out_space && ((state_q == decode_pkg::STALL) || !hazard);
    assign instr_accept_o = instr_valid_i && instr_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            decode_pkg::RUN: begin
                if (instr_valid_i && hazard && out_space) begin
                    state_d = decode_pkg::STALL;
                end
            end
            decode_pkg::STALL: begin
                if (instr_accept_o) begin
                    state_d = decode_pkg::RUN;
                end
            end
            default: state_d = decode_pkg::RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= decode_pkg::RUN;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bundle assembly
    ////////////////////////////////////////////////////////////

    assign is_store = ctrl_i.lsu_valid && ctrl_i.lsu_ctrl[`LSU_CTRL_W-1];

    always_comb begin
        dec_d.alu_op    = ctrl_i.alu_op;
        dec_d.use_pc    = ctrl_i.use_pc;
        dec_d.op_b_imm  = ctrl_i.op_b_imm;
        dec_d.wb        = ctrl_i.wb;
        dec_d.rs1       = ctrl_i.uses_rs1 ? fields_i.rs1 : '0;
        dec_d.rs2       = ctrl_i.uses_rs2 ? fields_i.rs2 : '0;
        dec_d.rd        = (is_store || ctrl_i.illegal) ? '0 : fields_i.rd;
        dec_d.lsu_valid = ctrl_i.lsu_valid;
        dec_d.lsu_ctrl  = ctrl_i.lsu_ctrl;
        dec_d.illegal   = ctrl_i.illegal;

        case (ctrl_i.imm_fmt)
            decode_pkg::IMM_I:     dec_d.imm = imm_cand_i.i_imm;
            decode_pkg::IMM_S:     dec_d.imm = imm_cand_i.s_imm;
            decode_pkg::IMM_U:     dec_d.imm = imm_cand_i.u_imm;
            decode_pkg::IMM_SHAMT: dec_d.imm = imm_cand_i.shamt;
            default:               dec_d.imm = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            dec_valid_o <= 1'b0;
        end else if (out_space) begin
            dec_valid_o <= instr_accept_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_accept_o) begin
            dec_o <= dec_d;
        end
    end

    // Held bundle must not change until the consumer takes it
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_o))
        else $error("Decoded bundle changed under back-pressure");

    // The held hazard instruction goes through once the output has space
    a_stall_once: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == decode_pkg::STALL) && out_space |=> state_q == decode_pkg::RUN)
        else $error("Stall state outlived the accept");

    // Illegal opcodes must reach the output with no side effects
    a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dec_valid_o && dec_o.illegal |-> !dec_o.wb && !dec_o.lsu_valid)
        else $error("Illegal instruction with write-back or LSU request");

endmodule

`default_nettype wire

// ==== design/rv32_decoder.sv ====
// RV32I decoder top

`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module rv32_decoder (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                instr_valid_i,
    input  wire rv32_isa_pkg::word_t instr_i,
    output logic                     instr_ready_o,
    output logic                     dec_valid_o,
    output decode_pkg::decoded_t     dec_o,
    input  wire logic                dec_ready_i
);

    decode_pkg::reg_fields_t fields;
    decode_pkg::imm_cand_t   imm_cand;
    decode_pkg::ctrl_t       ctrl;
    logic                    rs1_match;
    logic                    rs2_match;
    logic                    instr_accept;  // Updates the previous destination

    operand_unit operand_unit_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_i        (instr_i),
        .instr_accept_i (instr_accept),
        .fields_o       (fields),
        .imm_cand_o     (imm_cand),
        .rs1_match_o    (rs1_match),
        .rs2_match_o    (rs2_match)
    );

    ctrl_decode ctrl_decode_inst (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    decode_stage decode_stage_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_valid_i  (instr_valid_i),
        .fields_i       (fields),
        .imm_cand_i     (imm_cand),
        .rs1_match_i    (rs1_match),
        .rs2_match_i    (rs2_match),
        .ctrl_i         (ctrl),
        .dec_ready_i    (dec_ready_i),
        .instr_ready_o  (instr_ready_o),
        .instr_accept_o (instr_accept),
        .dec_valid_o    (dec_valid_o),
        .dec_o          (dec_o)
    );

endmodule

`default_nettype wire

// ==== tests/decoder_model.svh ====
// Reference decoder model

`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

// Source registers read, bit 0 for rs1 and bit 1 for rs2
function automatic logic [1:0] ref_uses(input rv32_isa_pkg::word_t instr);
    case (instr[6:0])
        7'b0110011, 7'b0100011: return 2'b11;  // OP and STORE
        7'b0010011, 7'b0000011: return 2'b01;  // OP-IMM and LOAD
        default:                return 2'b00;
    endcase
endfunction

function automatic decode_pkg::decoded_t ref_decode(input rv32_isa_pkg::word_t instr);
    decode_pkg::decoded_t d;
    logic [1:0]           uses;
    logic                 shift;  // SLLI, SRLI or SRAI encoding
    logic [31:0]          imm_i;
    imm_i = {{20{instr[31]}}, instr[31:20]};
    uses  = ref_uses(instr);
    shift = (instr[13:12] == 2'b01) && (instr[31:25] == 7'h00 || instr[31:25] == 7'h20);
    d     = '0;
    d.wb  = 1'b1;
    case (instr[6:0])
        7'b0110011: d.alu_op = {instr[30], instr[14:12]};
        7'b0010011: begin
            d.alu_op = {instr[30] && shift, instr[14:12]};
            d.imm    = shift ? {27'b0, instr[24:20]} : imm_i;
        end
        7'b0110111: d.imm = {instr[31:12], 12'b0};
        7'b0010111: begin
            d.imm    = {instr[31:12], 12'b0};
            d.use_pc = 1'b1;
        end
        7'b0000011, 7'b0100011: begin
            // S format takes its low five bits from the rd field
            d.imm       = instr[5] ? {imm_i[31:5], instr[11:7]} : imm_i;
            d.wb        = 1'b0;
            d.lsu_valid = 1'b1;
            d.lsu_ctrl  = {instr[5], instr[14:12]};  // Bit 5 marks a store
        end
        default: begin
            d.wb      = 1'b0;
            d.illegal = 1'b1;
        end
    endcase
    d.op_b_imm = !d.illegal && (instr[6:0] != 7'b0110011);
    d.rs1      = uses[0] ? instr[19:15] : '0;
    d.rs2      = uses[1] ? instr[24:20] : '0;
    d.rd       = (d.illegal || instr[6:0] == 7'b0100011) ? '0 : instr[11:7];
    return d;
endfunction

// Read-after-write on the previous destination, never on x0
function automatic bit ref_hazard(input rv32_isa_pkg::word_t instr,
                                  input rv32_isa_pkg::reg_addr_t prev_rd);
    logic [1:0] uses;
    uses = ref_uses(instr);
    return (prev_rd != '0) && ((uses[0] && instr[19:15] == prev_rd) ||
                               (uses[1] && instr[24:20] == prev_rd));
endfunction

`endif

// ==== tests/tb_rv32_decoder.sv ====
// RV32I decoder testbench

`timescale 1ns/1ps
`default_nettype none

module tb_rv32_decoder;

    localparam int N_RANDOM = 300;
    localparam int N_TOTAL  = N_RANDOM + 10;  // Random plus directed instructions

    logic                    clk_i;
    logic                    rstn_i;
    logic                    instr_valid_i;
    rv32_isa_pkg::word_t     instr_i;
    logic                    instr_ready_o;
    logic                    dec_valid_o;
    decode_pkg::decoded_t    dec_o;
    logic                    dec_ready_i;

    logic [31:0]             lfsr;
    logic                    accepted;  // Input handshake on the coming edge
    logic                    held;      // Output stalled on the coming edge
    decode_pkg::decoded_t    held_dec;
    rv32_isa_pkg::reg_addr_t prev_rd;
    int                      bubbles;
    int                      n_acc;
    int                      n_out;
    rv32_isa_pkg::word_t     stim_q[$];
    decode_pkg::decoded_t    exp_q[$];

    `include "decoder_model.svh"

    rv32_decoder rv32_decoder_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o),
        .dec_ready_i   (dec_ready_i)
    );

    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////
    // Random source and checks
    //////////////////////////////////////////////////////////////

    // Taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("Error: %0d ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "Check failed");
    endtask

    task automatic check_decoded(input decode_pkg::decoded_t got,
                                 input decode_pkg::decoded_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_stall(input int got, input int exp);
        if (got != exp)
            report_error($sformatf("ready-low cycles %0d, expected %0d", got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    function automatic rv32_isa_pkg::word_t random_instr();
        logic [2:0] kind;
        logic [6:0] funct7;
        logic [2:0] funct3;
        logic [6:0] opcode;
        logic [5:0] regs;  // Three registers out of x0..x3, hazards stay common
        kind   = 3'(rand_bits(3));
        funct7 = 7'(rand_bits(7));
        funct3 = 3'(rand_bits(3));
        regs   = 6'(rand_bits(6));
        case (kind)
            3'd0:    opcode = 7'b0110011;
            3'd1:    opcode = 7'b0010011;
            3'd2: begin
                opcode = 7'b0010011;           // Legal immediate shift
                funct3 = {funct3[2], 2'b01};
                funct7 = {1'b0, funct7[5], 5'b0};
            end
            3'd3:    opcode = 7'b0110111;
            3'd4:    opcode = 7'b0010111;
            3'd5:    opcode = 7'b0000011;
            3'd6:    opcode = 7'b0100011;
            default: opcode = 7'(rand_bits(7));  // Mostly unknown
        endcase
        return {funct7, 3'b0, regs[5:4], 3'b0, regs[3:2], funct3, 3'b0, regs[1:0], opcode};
    endfunction

    // Holds each instruction until accepted, valid never waits on ready
    task automatic run_phase(input int target, input bit random_mode);
        while (n_acc < target) begin
            @(posedge clk_i);
            dec_ready_i <= random_mode ? (rand_bits(2) != 0) : 1'b1;
            if (!instr_valid_i || accepted) begin
                if (stim_q.size() != 0 && (!random_mode || rand_bits(2) != 0)) begin
                    instr_valid_i <= 1'b1;
                    instr_i       <= stim_q.pop_front();
                end else begin
                    instr_valid_i <= 1'b0;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Monitor, sampled between edges
    //////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (held) begin
                check_flag(dec_valid_o, 1'b1, "valid dropped while stalled");
                check_decoded(dec_o, held_dec, "bundle changed while stalled");
            end
            held     = dec_valid_o && !dec_ready_i;
            held_dec = dec_o;
            if (held)
                check_flag(instr_ready_o, 1'b0, "input ready under back-pressure");
            else if (instr_valid_i && !instr_ready_o)
                bubbles++;  // Output has space, so only a hazard bubble
            if (dec_valid_o && dec_ready_i) begin
                if (exp_q.size() == 0)
                    report_error("output bundle without an accepted instruction");
                else
                    check_decoded(dec_o, exp_q.pop_front(), "decoded bundle");
                n_out++;
            end
            accepted = instr_valid_i && instr_ready_o;
            if (accepted) begin
                check_stall(bubbles, ref_hazard(instr_i, prev_rd) ? 1 : 0);
                exp_q.push_back(ref_decode(instr_i));
                prev_rd = instr_i[11:7];
                bubbles = 0;
                n_acc++;
            end
        end
    end

    // Eight cycles per instruction is far past the slowest case
    initial begin
        #(N_TOTAL * 8 * 4 + 5 * 4);
        $display("Watchdog timeout: the run hung");
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        dec_ready_i   = 1'b1;
        lfsr          = 32'h7b65_5b3a;
        accepted      = 1'b0;
        held          = 1'b0;
        held_dec      = '0;
        prev_rd       = '0;
        bubbles       = 0;
        n_acc         = 0;
        n_out         = 0;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;

        // Hazard chain, x0 match and illegal opcodes at full rate
        stim_q.push_back({12'hffb, 5'd0, 3'd0, 5'd1, 7'b0010011});         // ADDI x1
        stim_q.push_back({7'd0, 5'd1, 5'd1, 3'd0, 5'd2, 7'b0110011});      // ADD on x1
        stim_q.push_back({7'b0100000, 5'd7, 5'd2, 3'b101, 5'd3, 7'b0010011}); // SRAI on x2
        stim_q.push_back({7'd0, 5'd3, 5'd0, 3'b010, 5'd8, 7'b0100011});    // SW of x3
        stim_q.push_back({20'habcde, 5'd0, 7'b0110111});                   // LUI x0
        stim_q.push_back({12'd4, 5'd0, 3'b010, 5'd5, 7'b0000011});         // LW from x0
        stim_q.push_back({20'h80001, 5'd6, 7'b0010111});                   // AUIPC x6
        stim_q.push_back({7'd0, 5'd6, 5'd6, 3'd0, 5'd0, 7'b1100011});      // BEQ
        stim_q.push_back({20'h12345, 5'd1, 7'b1101111});                   // JAL
        stim_q.push_back(32'h0ff0_000f);                                   // FENCE
        run_phase(10, 1'b0);

        stim_q.push_back(32'h0000_0073);  // ECALL opens the random phase
        repeat (N_RANDOM - 1) stim_q.push_back(random_instr());
        run_phase(N_TOTAL, 1'b1);

        dec_ready_i <= 1'b1;
        while (n_out < N_TOTAL) @(posedge clk_i);
        repeat (4) @(negedge clk_i);
        if (exp_q.size() != 0 || n_acc != N_TOTAL) begin
            report_error("instruction count mismatch at the end of the run");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
+incdir+tests
design/rv32_isa_pkg.sv
design/decode_pkg.sv
design/operand_unit.sv
design/ctrl_decode.sv
design/decode_stage.sv
design/rv32_decoder.sv
tests/tb_rv32_decoder.sv

// ==== Bender.yml ====
package:
  name: rv32_decoder

export_include_dirs:
  - design

sources:
  - design/rv32_isa_pkg.sv
  - design/decode_pkg.sv
  - design/operand_unit.sv
  - design/ctrl_decode.sv
  - design/decode_stage.sv
  - design/rv32_decoder.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv32_decoder.sv
